//--- design/cam_display_pkg.sv
// shared pixel, sync and write-port types for the display pipeline
// modules refer to these with cam_display_pkg:: scoped names
`default_nettype none

package cam_display_pkg;

    localparam int fb_addr_w  = 17; // stored image address width
    localparam int mem_rd_lat = 2;  // address reg + data reg in frame buffer
    localparam int out_lat    = 1;  // final output register

    // one stored pixel
    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } rgb565_t;

    // one displayed pixel
    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb888_t;

    typedef struct packed {
        logic hsync;   // active low
        logic vsync;   // active low
        logic blank_n; // high in visible area
        logic active;  // pixel carries image data
    } vga_sync_t;

    typedef struct packed {
        logic                 en;
        logic [fb_addr_w-1:0] addr;
        rgb565_t              data;
    } fb_wr_t;

    typedef enum logic {
        mode_color = 1'b0,
        mode_gray  = 1'b1
    } display_mode_e;

    // state of the sync bundle outside any pulse and outside the picture
    localparam vga_sync_t sync_idle = '{hsync: 1'b1, vsync: 1'b1, blank_n: 1'b0, active: 1'b0};

endpackage

`default_nettype wire

//--- design/vga_timing.sv
// raster counters for the VGA output, each stored pixel shown as a 2x2 block
// gives registered sync/blank and the frame-buffer address of the current pixel
`timescale 1ns/1ps
`default_nettype none

module vga_timing #(
    parameter int h_active = 640,
    parameter int h_front  = 16,
    parameter int h_sync   = 96,
    parameter int h_back   = 48,
    parameter int v_active = 480,
    parameter int v_front  = 10,
    parameter int v_sync   = 2,
    parameter int v_back   = 33
) (
    input  wire                                  clk_25_vga,
    input  wire                                  reset,
    output cam_display_pkg::vga_sync_t           raw_sync,
    output logic [cam_display_pkg::fb_addr_w-1:0] rd_addr
);

    localparam int aw       = cam_display_pkg::fb_addr_w;
    localparam int h_total  = h_active + h_front + h_sync + h_back;
    localparam int v_total  = v_active + v_front + v_sync + v_back;
    localparam int hs_start = h_active + h_front;
    localparam int hs_end   = hs_start + h_sync;
    localparam int vs_start = v_active + v_front;
    localparam int vs_end   = vs_start + v_sync;
    localparam logic [aw-1:0] img_w = aw'(h_active / 2); // stored pixels per line

    logic [$clog2(h_total)-1:0] h_count;
    logic [$clog2(v_total)-1:0] v_count;
    logic [aw-1:0]              line_base; // address of first pixel on this stored line
    logic                       h_last;
    logic                       v_last;
    logic                       pix_active;
    logic                       in_hsync;
    logic                       in_vsync;

    assign h_last     = (h_count == h_total - 1);
    assign v_last     = (v_count == v_total - 1);
    assign pix_active = (h_count < h_active) && (v_count < v_active);
    assign in_hsync   = (h_count >= hs_start) && (h_count < hs_end);
    assign in_vsync   = (v_count >= vs_start) && (v_count < vs_end);

    always_ff @(posedge clk_25_vga) begin
        if (reset) begin
            h_count   <= '0;
            v_count   <= '0;
            line_base <= '0;
        end else begin
            if (h_last) begin
                h_count <= '0;
                if (v_last) begin
                    v_count   <= '0;
                    line_base <= '0; // new frame
                end else begin
                    v_count <= v_count + 1'b1;
                    // each stored line is shown twice
                    if (v_count[0] && (v_count < v_active)) begin
                        line_base <= line_base + img_w;
                    end
                end
            end else begin
                h_count <= h_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_25_vga) begin
        if (reset) begin
            raw_sync <= cam_display_pkg::sync_idle;
            rd_addr  <= '0;
        end else begin
            raw_sync.hsync   <= ~in_hsync;
            raw_sync.vsync   <= ~in_vsync;
            raw_sync.blank_n <= pix_active;
            raw_sync.active  <= pix_active;
            rd_addr          <= pix_active ? line_base + aw'(h_count >> 1) : '0; // halved column
        end
    end

endmodule

`default_nettype wire

//--- design/display_mode_reg.sv
// grayscale/colour mode register, loads the switch only during vertical sync
// so a single frame is never drawn in two modes
`timescale 1ns/1ps
`default_nettype none

module display_mode_reg (
    input  wire                            clk_25_vga,
    input  wire                            reset,
    input  wire                            sw_grayscale,
    input  wire cam_display_pkg::vga_sync_t raw_sync,
    output cam_display_pkg::display_mode_e mode
);

    cam_display_pkg::display_mode_e sw_mode;

    assign sw_mode = sw_grayscale ? cam_display_pkg::mode_gray : cam_display_pkg::mode_color;

    always_ff @(posedge clk_25_vga) begin
        if (reset) begin
            mode <= cam_display_pkg::mode_color;
        end else if (!raw_sync.vsync) begin // between frames only
            mode <= sw_mode;
        end
    end

endmodule

`default_nettype wire

//--- design/frame_buffer.sv
// two-bank RGB565 frame buffer, write port routed by the bank boundary
// read data appears mem_rd_lat cycles after the address
`timescale 1ns/1ps
`default_nettype none

module frame_buffer #(
    parameter int bank_depth = 32768
) (
    input  wire                                  clk_25_vga,
    input  wire cam_display_pkg::fb_wr_t         fb_wr,
    input  wire [cam_display_pkg::fb_addr_w-1:0] rd_addr,
    output cam_display_pkg::rgb565_t             rd_data
);

    localparam int aw      = cam_display_pkg::fb_addr_w;
    localparam int bank_aw = $clog2(bank_depth);
    localparam logic [aw-1:0] bank_base = aw'(bank_depth); // first address of bank 1

    cam_display_pkg::rgb565_t bank0 [bank_depth];
    cam_display_pkg::rgb565_t bank1 [bank_depth];

    logic                     wr_hi;
    logic                     wr_en0;
    logic                     wr_en1;
    logic [bank_aw-1:0]       wr_off;
    logic                     rd_hi;
    logic [bank_aw-1:0]       rd_off;
    logic [bank_aw-1:0]       rd_off_q;
    logic                     rd_hi_q;
    logic                     rd_hi_qq; // lines up with q0/q1
    cam_display_pkg::rgb565_t q0;
    cam_display_pkg::rgb565_t q1;

    // word offset inside the bank that holds addr
    function automatic logic [bank_aw-1:0] bank_offset(input logic [aw-1:0] addr);
        logic [aw-1:0] off;
        off = (addr >= bank_base) ? addr - bank_base : addr;
        return off[bank_aw-1:0];
    endfunction

    assign wr_hi  = (fb_wr.addr >= bank_base);
    assign wr_en0 = fb_wr.en & ~wr_hi;
    assign wr_en1 = fb_wr.en & wr_hi;
    assign wr_off = bank_offset(fb_wr.addr);

    assign rd_hi  = (rd_addr >= bank_base);
    assign rd_off = bank_offset(rd_addr);

    always_ff @(posedge clk_25_vga) begin
        if (wr_en0) begin
            bank0[wr_off] <= fb_wr.data;
        end
        if (wr_en1) begin
            bank1[wr_off] <= fb_wr.data;
        end
    end

    always_ff @(posedge clk_25_vga) begin
        rd_off_q <= rd_off;        // address register
        rd_hi_q  <= rd_hi;
        q0       <= bank0[rd_off_q]; // data register
        q1       <= bank1[rd_off_q];
        rd_hi_qq <= rd_hi_q;
    end

    assign rd_data = rd_hi_qq ? q1 : q0;

endmodule

`default_nettype wire

//--- design/video_out_stage.sv
// output stage: RGB565 to RGB888, optional grayscale, blanking, one output register
// sync is delayed to match the frame-buffer read latency
`timescale 1ns/1ps
`default_nettype none

module video_out_stage (
    input  wire                                 clk_25_vga,
    input  wire                                 reset,
    input  wire cam_display_pkg::rgb565_t       rd_data,
    input  wire cam_display_pkg::vga_sync_t     raw_sync,
    input  wire cam_display_pkg::display_mode_e mode,
    output cam_display_pkg::vga_sync_t          vga_sync,
    output cam_display_pkg::rgb888_t            vga_rgb
);

    localparam int sync_depth = cam_display_pkg::mem_rd_lat + cam_display_pkg::out_lat;

    cam_display_pkg::vga_sync_t sync_pipe [sync_depth];
    cam_display_pkg::vga_sync_t sync_aligned; // same cycle as rd_data
    cam_display_pkg::rgb888_t   expanded;
    cam_display_pkg::rgb888_t   gray_pix;
    cam_display_pkg::rgb888_t   next_pix;
    logic [15:0]                r16;
    logic [15:0]                g16;
    logic [15:0]                b16;
    logic [15:0]                gray_sum;

    always_ff @(posedge clk_25_vga) begin
        if (reset) begin
            for (int i = 0; i < sync_depth; i++) begin
                sync_pipe[i] <= cam_display_pkg::sync_idle;
            end
        end else begin
            sync_pipe[0] <= raw_sync;
            for (int i = 1; i < sync_depth; i++) begin
                sync_pipe[i] <= sync_pipe[i-1];
            end
        end
    end

    assign sync_aligned = sync_pipe[cam_display_pkg::mem_rd_lat-1];
    assign vga_sync     = sync_pipe[sync_depth-1];

    // low bits filled with ones
    assign expanded.red   = {rd_data.red, 3'b111};
    assign expanded.green = {rd_data.green, 2'b11};
    assign expanded.blue  = {rd_data.blue, 3'b111};

    assign r16 = {8'd0, expanded.red};
    assign g16 = {8'd0, expanded.green};
    assign b16 = {8'd0, expanded.blue};

    // 76*R + 150*G + 26*B, max 64260 so 16 bits hold it
    assign gray_sum = (r16 << 6) + (r16 << 3) + (r16 << 2)
                    + (g16 << 7) + (g16 << 4) + (g16 << 2) + (g16 << 1)
                    + (b16 << 4) + (b16 << 3) + (b16 << 1);

    assign gray_pix = '{red: gray_sum[15:8], green: gray_sum[15:8], blue: gray_sum[15:8]};

    always_comb begin
        if (!sync_aligned.active) begin
            next_pix = '0; // blanked
        end else if (mode == cam_display_pkg::mode_gray) begin
            next_pix = gray_pix;
        end else begin
            next_pix = expanded;
        end
    end

    always_ff @(posedge clk_25_vga) begin
        if (reset) begin
            vga_rgb <= '0;
        end else begin
            vga_rgb <= next_pix;
        end
    end

endmodule

`default_nettype wire

//--- design/cam_display_top.sv
// display top: timing generator, mode register, frame buffer and output stage
// the frame-buffer write port is driven from outside on the VGA clock
`timescale 1ns/1ps
`default_nettype none

module cam_display_top #(
    parameter int h_active   = 640,
    parameter int h_front    = 16,
    parameter int h_sync     = 96,
    parameter int h_back     = 48,
    parameter int v_active   = 480,
    parameter int v_front    = 10,
    parameter int v_sync     = 2,
    parameter int v_back     = 33,
    parameter int bank_depth = 32768
) (
    input  wire                          clk_25_vga,
    input  wire                          reset,
    input  wire                          sw_grayscale,
    input  wire cam_display_pkg::fb_wr_t fb_wr,
    output cam_display_pkg::vga_sync_t   vga_sync,
    output cam_display_pkg::rgb888_t     vga_rgb
);

    cam_display_pkg::vga_sync_t            raw_sync; // counter-aligned timing
    logic [cam_display_pkg::fb_addr_w-1:0] rd_addr;
    cam_display_pkg::rgb565_t              rd_data;  // mem_rd_lat behind rd_addr
    cam_display_pkg::display_mode_e        mode;

    vga_timing #(
        .h_active (h_active),
        .h_front  (h_front),
        .h_sync   (h_sync),
        .h_back   (h_back),
        .v_active (v_active),
        .v_front  (v_front),
        .v_sync   (v_sync),
        .v_back   (v_back)
    ) vga_timing_inst (
        .clk_25_vga (clk_25_vga),
        .reset      (reset),
        .raw_sync   (raw_sync),
        .rd_addr    (rd_addr)
    );

    display_mode_reg display_mode_reg_inst (
        .clk_25_vga   (clk_25_vga),
        .reset        (reset),
        .sw_grayscale (sw_grayscale),
        .raw_sync     (raw_sync),
        .mode         (mode)
    );

    frame_buffer #(
        .bank_depth (bank_depth)
    ) frame_buffer_inst (
        .clk_25_vga (clk_25_vga),
        .fb_wr      (fb_wr),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data)
    );

    video_out_stage video_out_stage_inst (
        .clk_25_vga (clk_25_vga),
        .reset      (reset),
        .rd_data    (rd_data),
        .raw_sync   (raw_sync),
        .mode       (mode),
        .vga_sync   (vga_sync),
        .vga_rgb    (vga_rgb)
    );

endmodule

`default_nettype wire

//--- verification/cam_display_chk.sv
// protocol assertions for the display top, attached with bind
// checks blanking, hsync pulse width and frame-boundary mode changes
`timescale 1ns/1ps
`default_nettype none

module cam_display_chk #(
    parameter int h_sync = 96
) (
    input wire                                 clk_25_vga,
    input wire                                 reset,
    input wire cam_display_pkg::vga_sync_t     vga_sync,
    input wire cam_display_pkg::rgb888_t       vga_rgb,
    input wire cam_display_pkg::vga_sync_t     raw_sync,
    input wire cam_display_pkg::display_mode_e mode
);

    // black outside the visible area
    rgb_zero_in_blank: assert property (@(posedge clk_25_vga) disable iff (reset)
        !vga_sync.blank_n |-> (vga_rgb == '0))
        else $error("vga_rgb is not zero while blank_n is low");

    hsync_pulse_width: assert property (@(posedge clk_25_vga) disable iff (reset)
        $fell(vga_sync.hsync) |-> (!vga_sync.hsync) [*h_sync] ##1 vga_sync.hsync)
        else $error("hsync low pulse does not last h_sync cycles");

    // mode loads only during raw vsync
    mode_change_in_vsync: assert property (@(posedge clk_25_vga) disable iff (reset)
        $changed(mode) |-> !$past(raw_sync.vsync))
        else $error("display mode changed outside vertical sync");

endmodule

bind cam_display_top cam_display_chk #(
    .h_sync (h_sync)
) cam_display_chk_inst (
    .clk_25_vga (clk_25_vga),
    .reset      (reset),
    .vga_sync   (vga_sync),
    .vga_rgb    (vga_rgb),
    .raw_sync   (raw_sync),
    .mode       (mode)
);

`default_nettype wire

//--- verification/cam_display_tb.sv
// directed testbench for the display top with a small 16x8 raster
// loads a random image and then checks sync timing and every shown pixel
`timescale 1ns/1ps
`default_nettype none

module cam_display_tb;

    localparam int h_active = 16;
    localparam int h_front  = 2;
    localparam int h_sync   = 3;
    localparam int h_back   = 3;
    localparam int v_active = 8;
    localparam int v_front  = 1;
    localparam int v_sync   = 2;
    localparam int v_back   = 1;
    localparam int bank_depth = 16;
    localparam int h_total  = h_active + h_front + h_sync + h_back;
    localparam int v_total  = v_active + v_front + v_sync + v_back;
    localparam int img_w    = h_active / 2;
    localparam int img_px   = img_w * (v_active / 2); // spans both banks
    localparam int sel_hsync = 0;
    localparam int sel_vsync = 1;
    localparam int sel_blank = 2;

    logic                          clk_25_vga;
    logic                          reset;
    logic                          sw_grayscale;
    cam_display_pkg::fb_wr_t       fb_wr;
    cam_display_pkg::vga_sync_t    vga_sync;
    cam_display_pkg::rgb888_t      vga_rgb;
    cam_display_pkg::rgb565_t      model [img_px]; // reference copy of the image
    integer                        seed;
    int                            error_count;
    int                            check_count;

    cam_display_top #(
        .h_active (h_active), .h_front (h_front), .h_sync (h_sync), .h_back (h_back),
        .v_active (v_active), .v_front (v_front), .v_sync (v_sync), .v_back (v_back),
        .bank_depth (bank_depth)
    ) cam_display_top_inst (
        .clk_25_vga   (clk_25_vga),
        .reset        (reset),
        .sw_grayscale (sw_grayscale),
        .fb_wr        (fb_wr),
        .vga_sync     (vga_sync),
        .vga_rgb      (vga_rgb)
    );

    initial begin
        clk_25_vga = 1'b0;
        forever #20 clk_25_vga = ~clk_25_vga;
    end

    function automatic logic sync_bit(input int sel);
        case (sel)
            sel_hsync: return vga_sync.hsync;
            sel_vsync: return vga_sync.vsync;
            default:   return vga_sync.blank_n;
        endcase
    endfunction

    // shown pixel for a screen position after 2x2 doubling and RGB565 expansion
    function automatic cam_display_pkg::rgb888_t expected_pixel(input int line, input int col,
                                                                input logic gray);
        cam_display_pkg::rgb565_t p;
        cam_display_pkg::rgb888_t e;
        int                       y;
        p = model[(line / 2) * img_w + col / 2];
        e.red   = {p.red, 3'b111};
        e.green = {p.green, 2'b11};
        e.blue  = {p.blue, 3'b111};
        if (gray) begin
            y = (76 * int'(e.red) + 150 * int'(e.green) + 26 * int'(e.blue)) / 256;
            e = '{red: 8'(y), green: 8'(y), blue: 8'(y)};
        end
        return e;
    endfunction

    // counts falling-edge samples until the requested transition
    task automatic wait_edge(input int sel, input bit rising, input int limit,
                             input string what, output int cycles, output bit ok);
        logic prev;
        prev = sync_bit(sel);
        cycles = 0;
        ok = 1'b0;
        while (!ok && cycles < limit) begin
            @(negedge clk_25_vga);
            cycles++;
            if (rising ? (!prev && sync_bit(sel)) : (prev && !sync_bit(sel))) begin
                ok = 1'b1;
            end
            prev = sync_bit(sel);
        end
        if (!ok) begin
            error_count++;
            $display("timeout: %s did not %s within %0d cycles", what,
                     rising ? "rise" : "fall", limit);
        end
    endtask

    task automatic write_pixel(input int addr, input cam_display_pkg::rgb565_t data);
        @(posedge clk_25_vga);
        fb_wr <= '{en: 1'b1, addr: 17'(addr), data: data};
        model[addr] = data;
        @(posedge clk_25_vga);
        fb_wr.en <= 1'b0;
    endtask

    task automatic load_image();
        for (int i = 0; i < img_px; i++) begin
            write_pixel(i, cam_display_pkg::rgb565_t'(16'($random(seed))));
        end
    endtask

    // checks one whole frame and toggles the switch ahead of line flip_line
    task automatic check_frame(input logic gray, input int flip_line);
        bit                       ok;
        int                       n;
        cam_display_pkg::rgb888_t exp;
        wait_edge(sel_vsync, 1'b1, 2 * h_total * v_total, "vsync", n, ok);
        for (int line = 0; line < v_active && ok; line++) begin
            if (line == flip_line) begin
                @(posedge clk_25_vga);
                sw_grayscale <= ~sw_grayscale;
                @(negedge clk_25_vga);
            end
            wait_edge(sel_blank, 1'b1, 2 * h_total, "blank_n", n, ok);
            for (int col = 0; col < h_active && ok; col++) begin
                exp = expected_pixel(line, col, gray);
                check_count++;
                assert (vga_rgb == exp && vga_sync.blank_n && vga_sync.active
                        && vga_sync.hsync) else begin
                    error_count++;
                    $display("** Error @ %0t: line %0d col %0d rgb %h expected %h sync %b",
                             $time, line, col, vga_rgb, exp, vga_sync);
                end
                @(negedge clk_25_vga);
            end
        end
    endtask

    task automatic idle_after_reset();
        int n;
        @(negedge clk_25_vga);
        check_count++;
        assert (vga_sync.hsync && vga_sync.vsync && !vga_sync.blank_n && !vga_sync.active
                && vga_rgb == '0) else begin
            error_count++;
            $display("** Error @ %0t: outputs not idle in reset, sync %b rgb %h",
                     $time, vga_sync, vga_rgb);
        end
        @(posedge clk_25_vga);
        reset <= 1'b0;
        n = 0;
        @(negedge clk_25_vga);
        while (!vga_sync.blank_n && n < h_total) begin
            check_count++;
            assert (vga_sync.hsync && vga_sync.vsync && vga_rgb == '0) else begin
                error_count++;
                $display("** Error @ %0t: before first pixel sync %b rgb %h",
                         $time, vga_sync, vga_rgb);
            end
            @(negedge clk_25_vga);
            n++;
        end
        if (!vga_sync.blank_n) begin
            error_count++;
            $display("timeout: no active pixel within %0d cycles after reset", h_total);
        end
    endtask

    task automatic sync_period_and_pulse();
        bit ok;
        int n;
        wait_edge(sel_hsync, 1'b0, 2 * h_total, "hsync", n, ok);
        wait_edge(sel_hsync, 1'b0, 2 * h_total, "hsync", n, ok);
        check_count++;
        assert (!ok || n == h_total) else begin
            error_count++;
            $display("** Error @ %0t: hsync period %0d expected %0d", $time, n, h_total);
        end
        wait_edge(sel_vsync, 1'b0, 2 * h_total * v_total, "vsync", n, ok);
        wait_edge(sel_vsync, 1'b1, 2 * h_total * v_sync, "vsync", n, ok);
        check_count++;
        assert (!ok || n == v_sync * h_total) else begin
            error_count++;
            $display("** Error @ %0t: vsync pulse %0d cycles expected %0d",
                     $time, n, v_sync * h_total);
        end
    endtask

    task automatic gray_after_switch();
        bit ok;
        int n;
        wait_edge(sel_blank, 1'b1, 2 * h_total * v_total, "blank_n", n, ok);
        @(posedge clk_25_vga);
        sw_grayscale <= 1'b1; // set mid-frame so it takes effect next frame
        check_frame(1'b1, -1);
    endtask

    task automatic mid_frame_toggle();
        check_frame(1'b1, 3); // switch drops back to colour at line 3
        check_frame(1'b0, -1);
    endtask

    task automatic writes_during_display();
        bit ok;
        int n;
        wait_edge(sel_blank, 1'b1, 2 * h_total * v_total, "blank_n", n, ok);
        for (int k = 0; k < 6; k++) begin
            write_pixel((k % 2) * bank_depth + ({$random(seed)} % bank_depth),
                        cam_display_pkg::rgb565_t'(16'($random(seed))));
        end
        check_frame(1'b0, -1);
    endtask

    initial begin
        seed = 32'hfa3e;
        error_count = 0;
        check_count = 0;
        reset = 1'b1;
        sw_grayscale = 1'b0;
        fb_wr = '0;
        repeat (3) @(posedge clk_25_vga);
        idle_after_reset();
        sync_period_and_pulse();
        load_image();
        check_frame(1'b0, -1); // colour frame over both banks
        gray_after_switch();
        mid_frame_toggle();
        writes_during_display();
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- cam_display.f
design/cam_display_pkg.sv
design/vga_timing.sv
design/display_mode_reg.sv
design/frame_buffer.sv
design/video_out_stage.sv
design/cam_display_top.sv
verification/cam_display_chk.sv
verification/cam_display_tb.sv
